/* Makefile */
# Verilator build and run for the ADC16 controller testbench

VERILATOR ?= verilator
TOP       ?= adc16_controller_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
source/adc16_pkg.sv
source/adc16_cmd_if.sv
source/adc16_wb_regs.sv
source/adc16_cmd_fifo.sv
source/adc16_3wire_serializer.sv
source/adc16_controller.sv
dv/tb_clkgen.sv
dv/adc16_props.sv
dv/adc16_controller_tb.sv

/* dv/adc16_controller_tb.sv */
`timescale 1ns/1ps

module adc16_controller_tb;

  localparam int DRIVE_DLY  = 10;    // Inputs move this long after the rising edge
  localparam int ACK_LIMIT  = 20;    // Cycles allowed for ack or err
  localparam int POLL_LIMIT = 2000;  // Word-0 reads allowed while waiting for idle
  localparam int RSP_ACK    = 0;
  localparam int RSP_ERR    = 1;
  localparam int RSP_NONE   = 2;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic [1:0]  adc16_locked_i;
  logic        adc3wire_sclk_o;
  logic        adc3wire_sdata_o;
  logic [7:0]  adc3wire_csn_o;
  logic        adc16_reset_o;
  logic        adc16_snap_req_o;
  logic [7:0]  adc16_iserdes_bitslip_o;
  logic [4:0]  adc16_delay_tap_o;
  logic [63:0] adc16_delay_rst_o;

  logic [31:0] regs_m [4];    // Expected contents of words 0 to 3
  logic [31:0] cmd_exp [$];   // Accepted commands as {csel, addr, data}
  logic [31:0] frames_obs [$];  // Frames rebuilt from the pins, same layout
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          tests_failed = 0;
  int          test_err0;

  // Pin monitor state
  bit          mon_en = 1'b0;
  logic        in_frame = 1'b0;
  logic        sclk_prev = 1'b0;
  logic [7:0]  frame_csn;
  logic [23:0] frame_bits;
  int          frame_len;

  tb_clkgen #(.PERIOD_NS(100)) clkgen0 (.clk_o(wb_clk_i));

  adc16_controller dut0 (
    .wb_clk_i                (wb_clk_i),
    .wb_rst_i                (wb_rst_i),
    .wb_cyc_i                (wb_cyc_i),
    .wb_stb_i                (wb_stb_i),
    .wb_we_i                 (wb_we_i),
    .wb_adr_i                (wb_adr_i),
    .wb_sel_i                (wb_sel_i),
    .wb_dat_i                (wb_dat_i),
    .wb_dat_o                (wb_dat_o),
    .wb_ack_o                (wb_ack_o),
    .wb_err_o                (wb_err_o),
    .adc16_locked_i          (adc16_locked_i),
    .adc3wire_sclk_o         (adc3wire_sclk_o),
    .adc3wire_sdata_o        (adc3wire_sdata_o),
    .adc3wire_csn_o          (adc3wire_csn_o),
    .adc16_reset_o           (adc16_reset_o),
    .adc16_snap_req_o        (adc16_snap_req_o),
    .adc16_iserdes_bitslip_o (adc16_iserdes_bitslip_o),
    .adc16_delay_tap_o       (adc16_delay_tap_o),
    .adc16_delay_rst_o       (adc16_delay_rst_o)
  );

  ////////////////////////////////////////
  // Checking and bookkeeping
  ////////////////////////////////////////
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("ERROR time %0t %s", $time, what);
  endtask

  task automatic begin_test();
    test_err0 = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    end
  endtask

  ////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////
  task automatic bus_cycle(input logic we, input logic [2:0] idx, input logic [3:0] sel,
                           input logic [31:0] dat, output logic [31:0] rdat,
                           output int status);
    int n;
    @(posedge wb_clk_i);
    #DRIVE_DLY;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {27'($urandom()), idx, 2'b00};  // Upper bits are not decoded here
    wb_sel_i = sel;
    wb_dat_i = dat;
    status   = RSP_NONE;
    rdat     = '0;
    for (n = 0; n < ACK_LIMIT && status == RSP_NONE; n++) begin
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      if (wb_ack_o) begin
        status = RSP_ACK;
        rdat   = wb_dat_o;
      end else if (wb_err_o) begin
        status = RSP_ERR;
      end
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (status == RSP_NONE) begin
      report_fail($sformatf("no ack or err on %s of word %0d", we ? "write" : "read", idx));
    end else begin
      if (n != 1) report_fail("response came later than one cycle after the request");
      if (we && status == RSP_ACK) begin
        check_val("wb_dat_o on a write ack", 64'(rdat), 64'd0);  // Only read acks carry data
      end
    end
  endtask

  task automatic bus_write(input logic [2:0] idx, input logic [3:0] sel,
                           input logic [31:0] dat, output int status);
    logic [31:0] unused_rd;
    bus_cycle(1'b1, idx, sel, dat, unused_rd, status);
  endtask

  task automatic bus_read(input logic [2:0] idx, output logic [31:0] rdat);
    int status;
    bus_cycle(1'b0, idx, 4'hf, 32'($urandom()), rdat, status);
    if (status == RSP_ERR) report_fail($sformatf("err answer on a read of word %0d", idx));
  endtask

  ////////////////////////////////////////
  // Register model
  ////////////////////////////////////////
  task automatic model_write(input logic [2:0] idx, input logic [3:0] sel,
                             input logic [31:0] dat);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    if (idx < 3'd4) regs_m[idx[1:0]] = (regs_m[idx[1:0]] & ~mask) | (dat & mask);
  endtask

  function automatic logic [31:0] expected_read(input logic [2:0] idx,
                                                input logic [1:0] locked, input logic busy);
    adc16_pkg::adc16_word0_u u;
    u = '0;
    if (idx == adc16_pkg::REG_WIRE) begin
      u.rd.zdok_rev   = adc16_pkg::ZDOK_REV;
      u.rd.busy       = busy;
      u.rd.locked     = locked;
      u.rd.num_units  = adc16_pkg::NUM_UNITS;
      u.rd.roach2_rev = adc16_pkg::ROACH2_REV;
      u.rd.low        = regs_m[0][15:0];
      return u;
    end
    if (idx < 3'd4) return regs_m[idx[1:0]];
    return '0;  // Command port and unused words
  endfunction

  task automatic check_outputs();
    check_val("adc16_reset_o", 64'(adc16_reset_o), 64'(regs_m[1][20]));
    check_val("adc16_snap_req_o", 64'(adc16_snap_req_o), 64'(regs_m[1][16]));
    check_val("adc16_iserdes_bitslip_o", 64'(adc16_iserdes_bitslip_o), 64'(regs_m[1][15:8]));
    check_val("adc16_delay_tap_o", 64'(adc16_delay_tap_o), 64'(regs_m[1][4:0]));
    check_val("adc16_delay_rst_o", adc16_delay_rst_o, {regs_m[3], regs_m[2]});
  endtask

  // Busy drops for one idle cycle between queued frames, so ask for two idle reads in a row
  task automatic wait_idle();
    adc16_pkg::adc16_word0_u w;
    int zeros;
    int n;
    zeros = 0;
    for (n = 0; n < POLL_LIMIT && zeros < 2; n++) begin
      bus_read(adc16_pkg::REG_WIRE, w);
      zeros = w.rd.busy ? 0 : zeros + 1;
    end
    if (zeros < 2) report_fail("serializer still busy after the poll limit");
  endtask

  task automatic compare_frames();
    check_val("frame count", 64'(frames_obs.size()), 64'(cmd_exp.size()));
    while (cmd_exp.size() > 0 && frames_obs.size() > 0) begin
      check_val("3-wire frame", 64'(frames_obs.pop_front()), 64'(cmd_exp.pop_front()));
    end
    cmd_exp.delete();
    frames_obs.delete();
  endtask

  ////////////////////////////////////////
  // Pin monitor
  ////////////////////////////////////////
  // Sampled mid-cycle where the pins are settled
  always @(negedge wb_clk_i) begin
    if (!mon_en) begin
      in_frame = 1'b0;
    end else if (!in_frame) begin
      if (adc3wire_csn_o != 8'hff) begin  // Any select low opens a frame
        in_frame  = 1'b1;
        frame_csn = adc3wire_csn_o;
        frame_len = 0;
      end
    end else if (adc3wire_csn_o == 8'hff) begin
      in_frame = 1'b0;
      if (frame_len != adc16_pkg::CMD_BITS) begin
        report_fail($sformatf("frame carried %0d sclk pulses", frame_len));
      end
      frames_obs.push_back({~frame_csn, frame_bits});
    end else begin
      if (adc3wire_csn_o != frame_csn) report_fail("csn changed inside a frame");
      if (adc3wire_sclk_o && !sclk_prev) begin  // Data is taken on the sclk rise
        frame_bits = {frame_bits[22:0], adc3wire_sdata_o};
        frame_len++;
      end
    end
    sclk_prev = adc3wire_sclk_o;
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic reset_test();
    logic [31:0] rd;
    begin_test();
    check_outputs();
    check_val("adc3wire_csn_o", 64'(adc3wire_csn_o), 64'hff);
    check_val("adc3wire_sclk_o", 64'(adc3wire_sclk_o), 64'd0);
    check_val("adc3wire_sdata_o", 64'(adc3wire_sdata_o), 64'd0);
    for (int i = 1; i < 8; i++) begin
      bus_read(3'(i), rd);
      check_val($sformatf("wb_dat_o word %0d", i), 64'(rd), 64'd0);
    end
    end_test("reset state");
  endtask

  task automatic register_test();
    logic [2:0]  idx;
    logic [3:0]  sel;
    logic [31:0] dat;
    logic [31:0] rd;
    int          status;
    begin_test();
    repeat (24) begin
      idx = 3'($urandom_range(0, 3));
      sel = 4'($urandom_range(0, 15));
      dat = $urandom();
      bus_write(idx, sel, dat, status);
      check_val("write response", 64'(status), 64'(RSP_ACK));
      model_write(idx, sel, dat);
      check_outputs();
      for (int i = 0; i < 4; i++) begin
        bus_read(3'(i), rd);
        check_val($sformatf("wb_dat_o word %0d", i), 64'(rd),
                  64'(expected_read(3'(i), adc16_locked_i, 1'b0)));
      end
    end
    end_test("register byte lanes");
  endtask

  task automatic status_test();
    logic [31:0] rd;
    begin_test();
    repeat (8) begin
      @(posedge wb_clk_i);
      #DRIVE_DLY;
      adc16_locked_i = 2'($urandom());
      bus_read(adc16_pkg::REG_WIRE, rd);
      check_val("wb_dat_o word 0", 64'(rd), 64'(expected_read(3'd0, adc16_locked_i, 1'b0)));
    end
    end_test("word 0 status fields");
  endtask

  task automatic manual_test();
    logic [3:0]  sel;
    logic [31:0] dat;
    logic [7:0]  csn_exp;
    int          status;
    begin_test();
    repeat (16) begin
      sel = 4'($urandom_range(0, 15));
      dat = $urandom();
      bus_write(adc16_pkg::REG_WIRE, sel, dat, status);
      model_write(adc16_pkg::REG_WIRE, sel, dat);
      csn_exp = ~regs_m[0][7:0];  // Active-low selects, one per chip
      check_val("adc3wire_sclk_o", 64'(adc3wire_sclk_o), 64'(regs_m[0][9]));
      check_val("adc3wire_sdata_o", 64'(adc3wire_sdata_o), 64'(regs_m[0][8]));
      check_val("adc3wire_csn_o", 64'(adc3wire_csn_o), 64'(csn_exp));
    end
    end_test("manual 3-wire pins");
  endtask

  task automatic command_test();
    logic [31:0] cmd;
    int          status;
    begin_test();
    bus_write(adc16_pkg::REG_WIRE, 4'hf, 32'd0, status);  // Park the pins with all csn high
    model_write(adc16_pkg::REG_WIRE, 4'hf, 32'd0);
    mon_en = 1'b1;
    repeat (5) begin
      cmd = {8'($urandom_range(1, 255)), 24'($urandom())};
      bus_write(adc16_pkg::REG_CMD, 4'hf, cmd, status);
      check_val("command write response", 64'(status), 64'(RSP_ACK));
      if (status == RSP_ACK) cmd_exp.push_back(cmd);
      wait_idle();
    end
    compare_frames();
    end_test("command frames");
  endtask

  task automatic overflow_test();
    logic [31:0] cmd;
    int          status;
    int          n_err;
    begin_test();
    n_err = 0;
    repeat (8) begin
      cmd = {8'($urandom_range(1, 255)), 24'($urandom())};
      bus_write(adc16_pkg::REG_CMD, 4'hf, cmd, status);
      if (status == RSP_ACK) cmd_exp.push_back(cmd);
      if (status == RSP_ERR) n_err++;
    end
    checks++;
    assert (n_err > 0) else report_fail("eight quick command writes never got an err answer");
    wait_idle();
    compare_frames();
    mon_en = 1'b0;
    end_test("command FIFO overflow");
  endtask

  initial begin
    void'($urandom(29960));
    wb_rst_i       = 1'b1;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_sel_i       = '0;
    wb_dat_i       = '0;
    adc16_locked_i = '0;
    for (int i = 0; i < 4; i++) regs_m[i] = '0;
    repeat (10) @(posedge wb_clk_i);
    #DRIVE_DLY;
    wb_rst_i = 1'b0;

    reset_test();
    register_test();
    status_test();
    manual_test();
    command_test();
    overflow_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/adc16_props.sv */
`timescale 1ns/1ps

module adc16_props (
  input logic       wb_clk_i,
  input logic       wb_rst_i,
  input logic       cyc_i,
  input logic       stb_i,
  input logic       ack_i,
  input logic       err_i,
  input logic       busy_i,
  input logic       sclk_i,
  input logic [7:0] csn_i
);

  ////////////////////////////////////////
  // Wishbone response rules
  ////////////////////////////////////////
  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(ack_i && err_i)) else $error("ack and err high in the same cycle");

  // Single-cycle response, so the master can start again every second cycle
  a_resp_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (ack_i || err_i) |=> !(ack_i || err_i)) else $error("response held for two cycles");

  a_resp_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (ack_i || err_i) |-> $past(cyc_i && stb_i)) else $error("response without a request");

  ////////////////////////////////////////
  // 3-wire pins during a frame
  ////////////////////////////////////////
  // Manual mode may move csn freely, so only engine frames are covered
  a_csn_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (busy_i && sclk_i && $past(sclk_i)) |-> $stable(csn_i))
    else $error("csn moved while sclk was high");

endmodule

bind adc16_controller adc16_props props0 (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .cyc_i    (wb_cyc_i),
  .stb_i    (wb_stb_i),
  .ack_i    (wb_ack_o),
  .err_i    (wb_err_o),
  .busy_i   (busy),
  .sclk_i   (adc3wire_sclk_o),
  .csn_i    (adc3wire_csn_o)
);

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps

// Free-running testbench clock, low for the first half period
module tb_clkgen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // Rising edges at 50, 150, 250 ns
  end

endmodule

/* source/adc16_3wire_serializer.sv */
`timescale 1ns/1ps

module adc16_3wire_serializer (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  adc16_cmd_if.consumer pop_if,
  input  logic       man_sclk_i,
  input  logic       man_sdata_i,
  input  logic [7:0] man_csel_i,
  output logic       busy_o,
  output logic       adc3wire_sclk_o,
  output logic       adc3wire_sdata_o,
  output logic [7:0] adc3wire_csn_o
);

  logic [2:0]                     state_q;
  logic [adc16_pkg::HALF_W-1:0]   hcnt_q;   // Cycles into the current sclk half
  logic [adc16_pkg::BIT_W-1:0]    bit_q;    // Bit being sent
  logic                           ph_q;     // Low half 0, high half 1
  logic [adc16_pkg::CMD_BITS-1:0] shift_q;  // MSB drives sdata
  logic [7:0]                     csel_q;
  logic                           half_done;
  logic                           bit_done;

  assign pop_if.ready = (state_q == adc16_pkg::ST_IDLE);  // Take a command only when idle
  assign busy_o       = (state_q != adc16_pkg::ST_IDLE);
  assign half_done    = (hcnt_q == adc16_pkg::HALF_W'(adc16_pkg::SCLK_HALF - 1));
  assign bit_done     = (state_q == adc16_pkg::ST_SHIFT) & half_done & ph_q;

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q <= adc16_pkg::ST_IDLE;
      hcnt_q  <= '0;
      bit_q   <= '0;
      ph_q    <= 1'b0;
    end else begin
      case (state_q)
        adc16_pkg::ST_IDLE: begin
          if (pop_if.valid) state_q <= adc16_pkg::ST_SETUP;  // csn drops next cycle
        end
        adc16_pkg::ST_SETUP: begin
          state_q <= adc16_pkg::ST_SHIFT;
          hcnt_q  <= '0;
          bit_q   <= '0;
          ph_q    <= 1'b0;
        end
        adc16_pkg::ST_SHIFT: begin
          hcnt_q <= half_done ? '0 : hcnt_q + 1'b1;
          if (half_done) begin
            ph_q <= ~ph_q;  // sclk rises mid-bit and falls at the bit boundary
          end
          if (bit_done) begin
            if (bit_q == adc16_pkg::BIT_W'(adc16_pkg::CMD_BITS - 1)) begin
              state_q <= adc16_pkg::ST_HOLD;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        adc16_pkg::ST_HOLD: state_q <= adc16_pkg::ST_GAP;  // Keep csn low one more cycle
        adc16_pkg::ST_GAP:  state_q <= adc16_pkg::ST_IDLE;
        default:            state_q <= adc16_pkg::ST_IDLE;
      endcase
    end
  end

  // Next bit appears while sclk is low
  always_ff @(posedge wb_clk_i) begin
    if (pop_if.valid & pop_if.ready) begin
      shift_q <= {pop_if.addr, pop_if.data};
      csel_q  <= pop_if.csel;
    end else if (bit_done) begin
      shift_q <= {shift_q[adc16_pkg::CMD_BITS-2:0], 1'b0};
    end
  end

  ////////////////////////////////////////
  // Pin mux
  ////////////////////////////////////////
  always_comb begin
    case (state_q)
      adc16_pkg::ST_IDLE: begin
        adc3wire_sclk_o  = man_sclk_i;   // Software bit-bangs through word 0
        adc3wire_sdata_o = man_sdata_i;
        adc3wire_csn_o   = ~man_csel_i;
      end
      adc16_pkg::ST_GAP: begin
        adc3wire_sclk_o  = 1'b0;
        adc3wire_sdata_o = 1'b0;
        adc3wire_csn_o   = '1;  // Deselect all chips between frames
      end
      default: begin
        adc3wire_sclk_o  = (state_q == adc16_pkg::ST_SHIFT) & ph_q;
        adc3wire_sdata_o = shift_q[adc16_pkg::CMD_BITS-1];
        adc3wire_csn_o   = ~csel_q;
      end
    endcase
  end

endmodule

/* source/adc16_cmd_fifo.sv */
`timescale 1ns/1ps

module adc16_cmd_fifo (
  input logic wb_clk_i,
  input logic wb_rst_i,
  adc16_cmd_if.consumer push_if,
  adc16_cmd_if.producer pop_if
);

  logic [31:0]                   mem [adc16_pkg::FIFO_DEPTH];  // {csel, addr, data}
  logic [adc16_pkg::FIFO_AW-1:0] wr_ptr;
  logic [adc16_pkg::FIFO_AW-1:0] rd_ptr;
  logic [adc16_pkg::FIFO_AW:0]   count;
  logic                          do_push;
  logic                          do_pop;

  // Wrap at the last entry so any depth works
  function automatic logic [adc16_pkg::FIFO_AW-1:0] ptr_inc(
      input logic [adc16_pkg::FIFO_AW-1:0] p);
    return (p == adc16_pkg::FIFO_AW'(adc16_pkg::FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push_if.ready = (count != (adc16_pkg::FIFO_AW + 1)'(adc16_pkg::FIFO_DEPTH));
  assign pop_if.valid  = (count != '0);  // Registered count, so no fall-through
  assign {pop_if.csel, pop_if.addr, pop_if.data} = mem[rd_ptr];

  assign do_push = push_if.valid & push_if.ready;
  assign do_pop  = pop_if.valid & pop_if.ready;

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= {push_if.csel, push_if.addr, push_if.data};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither leaves the fill level alone
      endcase
    end
  end

endmodule

/* source/adc16_cmd_if.sv */
`timescale 1ns/1ps

// One 3-wire command with a valid/ready handshake
interface adc16_cmd_if;

  logic        valid;
  logic        ready;
  logic [7:0]  csel;   // Chip select mask
  logic [7:0]  addr;   // ADC register address
  logic [15:0] data;   // ADC register data

  // Fields hold still while valid waits for ready
  modport producer (output valid, output csel, output addr, output data, input ready);
  modport consumer (input valid, input csel, input addr, input data, output ready);

endinterface

/* source/adc16_controller.sv */
`timescale 1ns/1ps

module adc16_controller (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  input  logic [1:0]  adc16_locked_i,
  output logic        adc3wire_sclk_o,
  output logic        adc3wire_sdata_o,
  output logic [7:0]  adc3wire_csn_o,  // Both boards share one select bus
  output logic        adc16_reset_o,
  output logic        adc16_snap_req_o,
  output logic [7:0]  adc16_iserdes_bitslip_o,
  output logic [4:0]  adc16_delay_tap_o,
  output logic [63:0] adc16_delay_rst_o
);

  logic       man_sclk;
  logic       man_sdata;
  logic [7:0] man_csel;
  logic       busy;

  adc16_cmd_if push_if ();  // Register block to FIFO
  adc16_cmd_if pop_if ();   // FIFO to serializer

  adc16_wb_regs u_regs (
    .wb_clk_i                (wb_clk_i),
    .wb_rst_i                (wb_rst_i),
    .wb_cyc_i                (wb_cyc_i),
    .wb_stb_i                (wb_stb_i),
    .wb_we_i                 (wb_we_i),
    .wb_adr_i                (wb_adr_i),
    .wb_sel_i                (wb_sel_i),
    .wb_dat_i                (wb_dat_i),
    .wb_dat_o                (wb_dat_o),
    .wb_ack_o                (wb_ack_o),
    .wb_err_o                (wb_err_o),
    .adc16_locked_i          (adc16_locked_i),
    .busy_i                  (busy),
    .man_sclk_o              (man_sclk),
    .man_sdata_o             (man_sdata),
    .man_csel_o              (man_csel),
    .adc16_reset_o           (adc16_reset_o),
    .adc16_snap_req_o        (adc16_snap_req_o),
    .adc16_iserdes_bitslip_o (adc16_iserdes_bitslip_o),
    .adc16_delay_tap_o       (adc16_delay_tap_o),
    .adc16_delay_rst_o       (adc16_delay_rst_o),
    .push_if                 (push_if.producer)
  );

  adc16_cmd_fifo u_fifo (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .push_if  (push_if.consumer),
    .pop_if   (pop_if.producer)
  );

  adc16_3wire_serializer u_ser (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .pop_if           (pop_if.consumer),
    .man_sclk_i       (man_sclk),
    .man_sdata_i      (man_sdata),
    .man_csel_i       (man_csel),
    .busy_o           (busy),
    .adc3wire_sclk_o  (adc3wire_sclk_o),
    .adc3wire_sdata_o (adc3wire_sdata_o),
    .adc3wire_csn_o   (adc3wire_csn_o)
  );

endmodule

/* source/adc16_pkg.sv */
package adc16_pkg;

  ////////////////////////////////////////
  // Board identity and sizing
  ////////////////////////////////////////
  localparam logic [1:0] ROACH2_REV = 2'd2;  // Carrier revision this build expects
  localparam logic [1:0] ZDOK_REV   = 2'd2;  // Connector pinout revision
  localparam logic [3:0] NUM_UNITS  = 4'd8;  // ADC chips on the shared 3-wire bus

  localparam int FIFO_DEPTH = 4;                   // Commands buffered ahead of the serializer
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // Pointer width
  localparam int SCLK_HALF  = 4;                   // Clock cycles per sclk half period
  localparam int HALF_W     = $clog2(SCLK_HALF);
  localparam int CMD_BITS   = 24;                  // Address byte plus 16 data bits
  localparam int BIT_W      = $clog2(CMD_BITS);

  // Word indexes, taken from wb_adr_i[4:2]
  localparam logic [2:0] REG_WIRE   = 3'd0;
  localparam logic [2:0] REG_CTRL   = 3'd1;
  localparam logic [2:0] REG_DLY_LO = 3'd2;
  localparam logic [2:0] REG_DLY_HI = 3'd3;
  localparam logic [2:0] REG_CMD    = 3'd4;

  // Serializer FSM encodings
  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_SETUP = 3'd1;
  localparam logic [2:0] ST_SHIFT = 3'd2;
  localparam logic [2:0] ST_HOLD  = 3'd3;
  localparam logic [2:0] ST_GAP   = 3'd4;

  // Word 0 seen from the bus write side and from the read side
  typedef union packed {
    struct packed {
      logic [21:0] rsvd;
      logic        sclk;   // Manual sclk level
      logic        sdata;  // Manual sdata level
      logic [7:0]  csel;   // One bit per chip, high selects
    } wr;
    struct packed {
      logic [1:0]  rsvd0;
      logic [1:0]  zdok_rev;
      logic        rsvd1;
      logic        busy;        // Command frame in flight
      logic [1:0]  locked;      // Line clock lock, one bit per board
      logic [3:0]  num_units;
      logic [1:0]  rsvd2;
      logic [1:0]  roach2_rev;
      logic [15:0] low;         // Stored low half of the register
    } rd;
  } adc16_word0_u;

endpackage

/* source/adc16_wb_regs.sv */
`timescale 1ns/1ps

module adc16_wb_regs (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o,
  input  logic [1:0]  adc16_locked_i,
  input  logic        busy_i,
  output logic        man_sclk_o,
  output logic        man_sdata_o,
  output logic [7:0]  man_csel_o,
  output logic        adc16_reset_o,
  output logic        adc16_snap_req_o,
  output logic [7:0]  adc16_iserdes_bitslip_o,
  output logic [4:0]  adc16_delay_tap_o,
  output logic [63:0] adc16_delay_rst_o,
  adc16_cmd_if.producer push_if
);

  logic [31:0] wire_q;    // Word 0, manual 3-wire bits
  logic [31:0] ctrl_q;    // Word 1
  logic [31:0] dly_lo_q;  // Word 2
  logic [31:0] dly_hi_q;  // Word 3
  logic [31:0] rd_q;      // Read data held for the ack cycle
  logic [31:0] rdata;
  logic        ack_q;
  logic        err_q;
  logic        req;
  logic        cmd_req;
  logic        cmd_full;
  logic [2:0]  idx;
  adc16_pkg::adc16_word0_u wr_view;
  adc16_pkg::adc16_word0_u rd_view;

  // Replace only the byte lanes flagged in sel
  function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////
  assign idx      = wb_adr_i[4:2];                       // Range check lives in the bus decoder
  assign req      = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;  // No back-to-back transfers
  assign cmd_req  = req & wb_we_i & (idx == adc16_pkg::REG_CMD);
  assign cmd_full = cmd_req & ~push_if.ready;            // FIFO full, the command is dropped

  // Push pulse lines up with the accepting edge
  assign push_if.valid = cmd_req & push_if.ready;
  assign push_if.csel  = wb_dat_i[31:24];
  assign push_if.addr  = wb_dat_i[23:16];
  assign push_if.data  = wb_dat_i[15:0];

  ////////////////////////////////////////
  // Register outputs
  ////////////////////////////////////////
  assign wr_view     = wire_q;
  assign man_sclk_o  = wr_view.wr.sclk;
  assign man_sdata_o = wr_view.wr.sdata;
  assign man_csel_o  = wr_view.wr.csel;

  assign adc16_reset_o           = ctrl_q[20];
  assign adc16_snap_req_o        = ctrl_q[16];
  assign adc16_iserdes_bitslip_o = ctrl_q[15:8];  // One slip strobe per chip
  assign adc16_delay_tap_o       = ctrl_q[4:0];
  assign adc16_delay_rst_o       = {dly_hi_q, dly_lo_q};

  // Word 0 read view mixes build constants with live status
  always_comb begin
    rd_view               = '0;
    rd_view.rd.zdok_rev   = adc16_pkg::ZDOK_REV;
    rd_view.rd.busy       = busy_i;
    rd_view.rd.locked     = adc16_locked_i;  // Sampled when the read is accepted
    rd_view.rd.num_units  = adc16_pkg::NUM_UNITS;
    rd_view.rd.roach2_rev = adc16_pkg::ROACH2_REV;
    rd_view.rd.low        = wire_q[15:0];
  end

  always_comb begin
    case (idx)
      adc16_pkg::REG_WIRE:   rdata = rd_view;
      adc16_pkg::REG_CTRL:   rdata = ctrl_q;
      adc16_pkg::REG_DLY_LO: rdata = dly_lo_q;
      adc16_pkg::REG_DLY_HI: rdata = dly_hi_q;
      default:               rdata = '0;  // Command port and words 5 to 7 read zero
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      wire_q   <= '0;
      ctrl_q   <= '0;
      dly_lo_q <= '0;
      dly_hi_q <= '0;
    end else begin
      ack_q <= req & ~cmd_full;
      err_q <= cmd_full;
      if (req & wb_we_i) begin
        case (idx)
          adc16_pkg::REG_WIRE:   wire_q   <= lane_merge(wire_q, wb_dat_i, wb_sel_i);
          adc16_pkg::REG_CTRL:   ctrl_q   <= lane_merge(ctrl_q, wb_dat_i, wb_sel_i);
          adc16_pkg::REG_DLY_LO: dly_lo_q <= lane_merge(dly_lo_q, wb_dat_i, wb_sel_i);
          adc16_pkg::REG_DLY_HI: dly_hi_q <= lane_merge(dly_hi_q, wb_dat_i, wb_sel_i);
          default: ;  // Command word already went to the FIFO
        endcase
      end
    end
  end

  // Writes leave zero behind so the ack cycle shows a clean bus
  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_q <= wb_we_i ? '0 : rdata;
    end
  end

  assign wb_dat_o = ack_q ? rd_q : '0;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

endmodule
